// File: Makefile
# verilator build and run of the schedule controller testbench

TOP = tb_vnu_control_unit

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: decode_sched_fsm.sv
`timescale 1ns/100ps

// per-layer schedule: fetch, vnu pipe, shift, align, write back, idle
module decode_sched_fsm (
	input  logic                          read_clk,
	input  logic                          rstn,
	input  logic                          fsm_en_i,
	input  logic                          termination_i,
	input  vnu_timing_pkg::vnu_mask_t     vnu_pending_i, // vnu ib-ram loads still open
	output vnu_state_pkg::sched_state_t   state_o,
	output vnu_timing_pkg::stage_t        stage_o,
	output vnu_timing_pkg::layer_onehot_t layer_cnt_o,
	output logic                          last_layer_o,
	output logic                          layer_finish_o,
	output logic                          init_pulse_o,
	output logic                          vnu_update_pend_o
);

	vnu_state_pkg::sched_state_t   state_q;
	vnu_state_pkg::sched_state_t   state_d;
	vnu_timing_pkg::stage_t        stage_q;
	vnu_timing_pkg::layer_onehot_t layer_q;
	logic go;        // enabled and not terminated
	logic vnu_busy;  // any vnu ib-ram still being written
	logic timed;     // state with a stage count
	logic stage_end; // last cycle of the current state

	assign go       = fsm_en_i & ~termination_i;
	assign vnu_busy = |vnu_pending_i;

	////////////////////////////////////////
	// state length decode
	////////////////////////////////////////
	always_comb begin
		timed     = 1'b1;
		stage_end = 1'b1; // single-cycle states end at once
		case (state_q)
			vnu_state_pkg::MEM_FETCH: begin
				stage_end = (stage_q == vnu_timing_pkg::stage_t'(vnu_timing_pkg::MEM_RD_LEVEL - 1));
			end
			vnu_state_pkg::VNU_PIPE: begin
				// one level short, the last one runs in VNU_OUT
				stage_end = (stage_q == vnu_timing_pkg::stage_t'(vnu_timing_pkg::VNU_PIPE_LEVEL - 2));
			end
			vnu_state_pkg::BS_WB: begin
				stage_end = (stage_q ==
					vnu_timing_pkg::stage_t'(vnu_timing_pkg::PERMUTATION_LEVEL - 1));
			end
			vnu_state_pkg::IDLE: begin
				stage_end = (stage_q == vnu_timing_pkg::stage_t'(vnu_timing_pkg::IDLE_GAP - 1));
			end
			default: begin
				timed = 1'b0; // stall and one-cycle states keep stage at 0
			end
		endcase
	end

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		if (!go) begin
			state_d = vnu_state_pkg::INIT_LOAD; // restart the frame, ring kept
		end else begin
			case (state_q)
				vnu_state_pkg::INIT_LOAD:  state_d = vnu_state_pkg::CH_FETCH;
				vnu_state_pkg::CH_FETCH:   state_d = vnu_state_pkg::MEM_FETCH;
				vnu_state_pkg::MEM_FETCH: begin
					if (stage_end) begin
						state_d = vnu_busy ? vnu_state_pkg::VNU_IB_RAM_PEND
							: vnu_state_pkg::VNU_PIPE;
					end
				end
				vnu_state_pkg::VNU_IB_RAM_PEND: begin
					if (!vnu_busy) begin
						state_d = vnu_state_pkg::VNU_PIPE; // all vnu ib-rams written
					end
				end
				vnu_state_pkg::VNU_PIPE: begin
					if (stage_end) begin
						state_d = vnu_state_pkg::VNU_OUT;
					end
				end
				vnu_state_pkg::VNU_OUT:    state_d = vnu_state_pkg::BS_WB;
				vnu_state_pkg::BS_WB: begin
					if (stage_end) begin
						state_d = vnu_state_pkg::PAGE_ALIGN;
					end
				end
				vnu_state_pkg::PAGE_ALIGN: state_d = vnu_state_pkg::MEM_WB;
				vnu_state_pkg::MEM_WB:     state_d = vnu_state_pkg::IDLE;
				vnu_state_pkg::IDLE: begin
					if (stage_end) begin
						state_d = vnu_state_pkg::CH_FETCH; // next layer
					end
				end
				default:                   state_d = vnu_state_pkg::INIT_LOAD;
			endcase
		end
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= vnu_state_pkg::INIT_LOAD;
			stage_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_d == state_q && timed) begin
				stage_q <= stage_q + 1'b1;
			end else begin
				stage_q <= '0; // restart on every state change
			end
		end
	end

	////////////////////////////////////////
	// layer ring
	////////////////////////////////////////
	assign layer_finish_o = go && (state_q == vnu_state_pkg::IDLE) && stage_end;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			layer_q <= vnu_timing_pkg::layer_onehot_t'(1); // layer 0
		end else if (layer_finish_o) begin
			layer_q <= {layer_q[vnu_timing_pkg::LAYER_NUM-2:0],
				layer_q[vnu_timing_pkg::LAYER_NUM-1]};
		end
	end

	assign state_o      = state_q;
	assign stage_o      = stage_q;
	assign layer_cnt_o  = layer_q;
	assign last_layer_o = layer_q[vnu_timing_pkg::LAYER_NUM-1];
	assign init_pulse_o = go && (state_q == vnu_state_pkg::INIT_LOAD); // only on the way out
	assign vnu_update_pend_o = vnu_busy && ((state_q == vnu_state_pkg::MEM_FETCH) ||
		(state_q == vnu_state_pkg::VNU_IB_RAM_PEND));

	a_layer_onehot: assert property (
		@(posedge read_clk) disable iff (!rstn)
		$onehot(layer_q)
	) else $error("layer ring lost its one-hot pattern");

	// tracker flags must all be clear in the cycle the pipe is entered from
	a_pipe_after_loads: assert property (
		@(posedge read_clk) disable iff (!rstn)
		(state_q != vnu_state_pkg::VNU_PIPE) ##1 (state_q == vnu_state_pkg::VNU_PIPE)
			|-> ($past(vnu_pending_i) == '0)
	) else $error("vnu pipe entered with ib-ram load pending");

endmodule

// File: ib_ram_load_tracker.sv
`timescale 1ns/100ps

// write request flag towards one external ib-ram writer
// init and pipe loads share the same flag, so one start input covers both
module ib_ram_load_tracker (
	input  logic read_clk,
	input  logic rstn,
	input  logic start_i,       // one-cycle load request
	input  logic iter_update_i, // writer done, acks the request
	output logic wr_o,
	output logic pending_o
);

	logic wr_q; // request outstanding

	////////////////////////////////////////
	// request flag
	////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			wr_q <= 1'b0;
		end else if (wr_q) begin
			// a second start while busy is absorbed
			if (iter_update_i) begin
				wr_q <= 1'b0; // released on the ack cycle
			end
		end else if (start_i) begin
			wr_q <= 1'b1;
		end
	end

	assign wr_o      = wr_q;
	assign pending_o = wr_q; // fsm side sees the same level

	// a request only ever follows a start from the schedule
	a_wr_needs_start: assert property (
		@(posedge read_clk) disable iff (!rstn)
		$rose(wr_q) |-> $past(start_i)
	) else $error("ib-ram write request without a start pulse");

endmodule

// File: pipe_strobe_gen.sv
`timescale 1ns/100ps

// memory, shifter and unit strobes decoded from schedule state and stage
module pipe_strobe_gen (
	input  logic                        read_clk,
	input  logic                        rstn,
	input  vnu_state_pkg::sched_state_t state_i,
	input  vnu_timing_pkg::stage_t      stage_i,
	input  logic                        last_layer_i,
	output vnu_timing_pkg::vnu_mask_t   vnu_rd_o,
	output logic                        dnu_rd_o,
	output logic                        v2c_src_o,
	output logic                        v2c_bs_en_o,
	output logic                        v2c_pa_en_o,
	output logic                        v2c_mem_we_o,
	output vnu_timing_pkg::vnu_mask_t   vnu_pipe_start_o,
	output logic                        dnu_pipe_start_o,
	output logic                        hard_decision_done_o
);

	logic                      in_pipe;      // vnu pipeline running
	vnu_timing_pkg::vnu_mask_t vnu_rd_last;  // last cycle of each read window
	vnu_timing_pkg::vnu_mask_t vnu_start_q;
	logic                      dnu_close_q;  // dnu window closed on the last layer

	assign in_pipe = (state_i == vnu_state_pkg::VNU_PIPE);

	////////////////////////////////////////
	// vnu read windows
	////////////////////////////////////////
	for (genvar j = 0; j < vnu_timing_pkg::VNU_FUNC_NUM; j++) begin : g_vnu_rd
		// function j reads its ib-ram for VNU_FUNC_CYCLE stages
		assign vnu_rd_o[j] = in_pipe &&
			(stage_i >= vnu_timing_pkg::stage_t'(j * vnu_timing_pkg::VNU_FUNC_CYCLE)) &&
			(stage_i < vnu_timing_pkg::stage_t'((j + 1) * vnu_timing_pkg::VNU_FUNC_CYCLE));

		// window ends on its own edge or when the pipe state runs out
		assign vnu_rd_last[j] = vnu_rd_o[j] && (
			(stage_i == vnu_timing_pkg::stage_t'((j + 1) * vnu_timing_pkg::VNU_FUNC_CYCLE - 1)) ||
			(stage_i == vnu_timing_pkg::stage_t'(vnu_timing_pkg::VNU_PIPE_LEVEL - 2)));

		// ib-ram is free for next iteration's content once read on the last layer
		always_ff @(posedge read_clk or negedge rstn) begin
			if (!rstn) begin
				vnu_start_q[j] <= 1'b0;
			end else begin
				vnu_start_q[j] <= vnu_rd_last[j] && last_layer_i;
			end
		end
	end

	////////////////////////////////////////
	// dnu and v2c path
	////////////////////////////////////////
	assign dnu_rd_o = (state_i == vnu_state_pkg::BS_WB) ||
		(state_i == vnu_state_pkg::PAGE_ALIGN); // decision nodes work from shift to align

	assign v2c_src_o = (state_i == vnu_state_pkg::MEM_FETCH) &&
		(stage_i == vnu_timing_pkg::stage_t'(vnu_timing_pkg::MEM_RD_LEVEL - 1));
	assign v2c_bs_en_o  = (state_i == vnu_state_pkg::BS_WB) && (stage_i == '0); // first shift cycle
	assign v2c_pa_en_o  = (state_i == vnu_state_pkg::PAGE_ALIGN);
	assign v2c_mem_we_o = (state_i == vnu_state_pkg::MEM_WB);

	// PAGE_ALIGN is the last dnu read cycle, flop lands in MEM_WB
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			dnu_close_q <= 1'b0;
		end else begin
			dnu_close_q <= (state_i == vnu_state_pkg::PAGE_ALIGN) && last_layer_i;
		end
	end

	assign vnu_pipe_start_o = vnu_start_q;
	assign dnu_pipe_start_o = dnu_close_q;     // dnu ib-ram reload
	assign hard_decision_done_o = dnu_close_q; // decisions written with this MEM_WB

endmodule

// File: sim.f
vnu_timing_pkg.sv
vnu_state_pkg.sv
ib_ram_load_tracker.sv
decode_sched_fsm.sv
pipe_strobe_gen.sv
vnu_control_unit.sv
tb_vnu_control_unit.sv

// File: tb_vnu_control_unit.sv
`timescale 1ns/100ps

// random ib-ram writer latencies, every output compared with a cycle model
module tb_vnu_control_unit;

	localparam int CLK_PERIOD  = 4;
	localparam int VNUS        = vnu_timing_pkg::VNU_FUNC_NUM;
	localparam int LAYERS      = vnu_timing_pkg::LAYER_NUM;
	localparam int N_LAYERS    = 30;
	localparam int N_EVENTS    = 10; // termination pulses and enable drops
	localparam int WORST_LAYER = 40; // longest layer incl. a full ib-ram stall
	localparam int WATCHDOG_CYCLES = 3 + N_LAYERS * WORST_LAYER + N_EVENTS * 20 + 40 + 100;

	logic                          read_clk;
	logic                          rstn;
	logic                          fsm_en_i;
	logic                          termination_i;
	vnu_timing_pkg::vnu_mask_t     vn_iter_update_i;
	logic                          dn_iter_update_i;
	vnu_timing_pkg::vnu_mask_t     vnu_wr_o;
	logic                          dnu_wr_o;
	logic                          vnu_update_pend_o;
	vnu_timing_pkg::vnu_mask_t     vnu_rd_o;
	logic                          dnu_rd_o;
	logic                          v2c_src_o;
	logic                          v2c_bs_en_o;
	logic                          v2c_pa_en_o;
	logic                          v2c_mem_we_o;
	logic                          hard_decision_done_o;
	vnu_state_pkg::sched_state_t   state_o;
	vnu_timing_pkg::layer_onehot_t layer_cnt_o;
	logic                          last_layer_o;
	logic                          layer_finish_o;

	vnu_state_pkg::sched_state_t   m_state;
	int                            m_stage;
	vnu_timing_pkg::layer_onehot_t m_layer;
	logic [VNUS:0]                 m_wr;    // dnu flag in the top bit
	logic [VNUS:0]                 m_start; // registered pipe-load pulses, dnu on top
	int                            wait_cnt [VNUS+1]; // writer latency left, -1 when idle
	logic [31:0]                   lfsr_q;
	int                            err_cnt;
	int                            layer_done;
	int                            stall_cycles;
	int                            hdd_cnt;

	vnu_control_unit u_vnu_control_unit (.*);

	initial begin
		read_clk = 1'b0;
		forever #(CLK_PERIOD / 2) read_clk = ~read_clk;
	end

	////////////////////////////////////////
	// random numbers and compare
	////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0); // galois, right shift
	endfunction

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
		end
		return v;
	endfunction

	task automatic check_value(string test, string sig, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s %s expected %0h actual %0h at %0t", test, sig, exp, act, $time);
		end
	endtask

	////////////////////////////////////////
	// schedule model
	////////////////////////////////////////
	function automatic int state_len(vnu_state_pkg::sched_state_t s);
		case (s)
			vnu_state_pkg::MEM_FETCH:       return vnu_timing_pkg::MEM_RD_LEVEL;
			vnu_state_pkg::VNU_IB_RAM_PEND: return 0; // open ended
			vnu_state_pkg::VNU_PIPE:        return vnu_timing_pkg::VNU_PIPE_LEVEL - 1;
			vnu_state_pkg::BS_WB:           return vnu_timing_pkg::PERMUTATION_LEVEL;
			vnu_state_pkg::IDLE:            return vnu_timing_pkg::IDLE_GAP;
			default:                        return 1;
		endcase
	endfunction

	function automatic vnu_state_pkg::sched_state_t next_in_order(vnu_state_pkg::sched_state_t s);
		case (s)
			vnu_state_pkg::INIT_LOAD:  return vnu_state_pkg::CH_FETCH;
			vnu_state_pkg::CH_FETCH:   return vnu_state_pkg::MEM_FETCH;
			vnu_state_pkg::MEM_FETCH:  return vnu_state_pkg::VNU_PIPE;
			vnu_state_pkg::VNU_PIPE:   return vnu_state_pkg::VNU_OUT;
			vnu_state_pkg::VNU_OUT:    return vnu_state_pkg::BS_WB;
			vnu_state_pkg::BS_WB:      return vnu_state_pkg::PAGE_ALIGN;
			vnu_state_pkg::PAGE_ALIGN: return vnu_state_pkg::MEM_WB;
			vnu_state_pkg::MEM_WB:     return vnu_state_pkg::IDLE;
			default:                   return vnu_state_pkg::CH_FETCH; // next layer
		endcase
	endfunction

	// function j reads during stages j*3 .. j*3+2 of the pipe
	function automatic logic window_open(int j);
		return (m_state == vnu_state_pkg::VNU_PIPE) &&
			(m_stage >= j * vnu_timing_pkg::VNU_FUNC_CYCLE) &&
			(m_stage < (j + 1) * vnu_timing_pkg::VNU_FUNC_CYCLE);
	endfunction

	task automatic check_outputs(string test);
		logic                      go;
		logic                      busy;
		vnu_timing_pkg::vnu_mask_t rd;
		go   = fsm_en_i && !termination_i;
		busy = |m_wr[VNUS-1:0];
		for (int j = 0; j < VNUS; j++) begin
			rd[j] = window_open(j);
		end
		check_value(test, "state_o", 32'(m_state), 32'(state_o));
		check_value(test, "layer_cnt_o", 32'(m_layer), 32'(layer_cnt_o));
		check_value(test, "last_layer_o", 32'(m_layer[LAYERS-1]), 32'(last_layer_o));
		check_value(test, "layer_finish_o", 32'(go && m_state == vnu_state_pkg::IDLE &&
			m_stage == vnu_timing_pkg::IDLE_GAP - 1), 32'(layer_finish_o));
		check_value(test, "vnu_rd_o", 32'(rd), 32'(vnu_rd_o));
		check_value(test, "dnu_rd_o", 32'(m_state == vnu_state_pkg::BS_WB ||
			m_state == vnu_state_pkg::PAGE_ALIGN), 32'(dnu_rd_o));
		check_value(test, "v2c_src_o", 32'(m_state == vnu_state_pkg::MEM_FETCH &&
			m_stage == vnu_timing_pkg::MEM_RD_LEVEL - 1), 32'(v2c_src_o));
		check_value(test, "v2c_bs_en_o", 32'(m_state == vnu_state_pkg::BS_WB && m_stage == 0),
			32'(v2c_bs_en_o));
		check_value(test, "v2c_pa_en_o", 32'(m_state == vnu_state_pkg::PAGE_ALIGN),
			32'(v2c_pa_en_o));
		check_value(test, "v2c_mem_we_o", 32'(m_state == vnu_state_pkg::MEM_WB),
			32'(v2c_mem_we_o));
		check_value(test, "hard_decision_done_o", 32'(m_start[VNUS]), 32'(hard_decision_done_o));
		check_value(test, "vnu_wr_o", 32'(m_wr[VNUS-1:0]), 32'(vnu_wr_o));
		check_value(test, "dnu_wr_o", 32'(m_wr[VNUS]), 32'(dnu_wr_o));
		check_value(test, "vnu_update_pend_o", 32'(busy && (m_state == vnu_state_pkg::MEM_FETCH ||
			m_state == vnu_state_pkg::VNU_IB_RAM_PEND)), 32'(vnu_update_pend_o));
	endtask

	task automatic advance_model();
		logic                        go;
		logic                        busy;
		logic                        last;
		logic [VNUS:0]               start;
		logic [VNUS:0]               acks;
		logic [VNUS:0]               nxt_start;
		vnu_state_pkg::sched_state_t nxt;
		int                          len;
		int                          win_last;
		go    = fsm_en_i && !termination_i;
		busy  = |m_wr[VNUS-1:0];
		last  = m_layer[LAYERS-1];
		len   = state_len(m_state);
		acks  = {dn_iter_update_i, vn_iter_update_i};
		start = m_start | {(VNUS + 1){go && m_state == vnu_state_pkg::INIT_LOAD}};
		for (int j = 0; j < VNUS; j++) begin
			win_last = (j + 1) * vnu_timing_pkg::VNU_FUNC_CYCLE - 1;
			if (win_last > state_len(vnu_state_pkg::VNU_PIPE) - 1) begin
				win_last = state_len(vnu_state_pkg::VNU_PIPE) - 1; // clipped by the pipe end
			end
			nxt_start[j] = last && window_open(j) && (m_stage == win_last);
		end
		nxt_start[VNUS] = last && (m_state == vnu_state_pkg::PAGE_ALIGN);
		if (!go) begin
			nxt = vnu_state_pkg::INIT_LOAD;
		end else if (m_state == vnu_state_pkg::VNU_IB_RAM_PEND) begin
			nxt = busy ? m_state : vnu_state_pkg::VNU_PIPE;
		end else if (m_stage == len - 1) begin
			nxt = (m_state == vnu_state_pkg::MEM_FETCH && busy) ?
				vnu_state_pkg::VNU_IB_RAM_PEND : next_in_order(m_state);
		end else begin
			nxt = m_state;
		end
		stall_cycles += int'(m_state == vnu_state_pkg::VNU_IB_RAM_PEND);
		hdd_cnt += int'(m_start[VNUS]);
		if (go && m_state == vnu_state_pkg::IDLE && m_stage == len - 1) begin
			m_layer = {m_layer[LAYERS-2:0], m_layer[LAYERS-1]}; // ring moves on
			layer_done++;
		end
		for (int k = 0; k <= VNUS; k++) begin
			m_wr[k] = m_wr[k] ? !acks[k] : start[k]; // start absorbed while busy
		end
		m_start = nxt_start;
		m_stage = (nxt == m_state && len > 1) ? m_stage + 1 : 0;
		m_state = nxt;
	endtask

	////////////////////////////////////////
	// ib-ram writers and cycle stepping
	////////////////////////////////////////
	task automatic drive_acks();
		logic [VNUS:0] wr_seen;
		logic [VNUS:0] ack;
		wr_seen = {dnu_wr_o, vnu_wr_o};
		ack     = '0;
		for (int k = 0; k <= VNUS; k++) begin
			if (wait_cnt[k] < 0 && wr_seen[k]) begin
				wait_cnt[k] = take_bits(3); // 0..7 cycles
			end
			ack[k] = (wait_cnt[k] == 0);
			if (wait_cnt[k] >= 0) begin
				wait_cnt[k]--;
			end
		end
		vn_iter_update_i = ack[VNUS-1:0];
		dn_iter_update_i = ack[VNUS];
	endtask

	// entered on a falling edge, left on the next one
	task automatic run_cycle(string test, logic en, logic term);
		fsm_en_i      = en;
		termination_i = term;
		drive_acks();
		#1;
		check_outputs(test);
		advance_model();
		@(negedge read_clk);
	endtask

	initial begin : main_seq
		int                            gap;
		int                            drop;
		vnu_timing_pkg::layer_onehot_t layer_before;
		lfsr_q       = 32'd69335;
		err_cnt      = 0;
		layer_done   = 0;
		stall_cycles = 0;
		hdd_cnt      = 0;
		m_state      = vnu_state_pkg::INIT_LOAD;
		m_stage      = 0;
		m_layer      = vnu_timing_pkg::layer_onehot_t'(1);
		m_wr         = '0;
		m_start      = '0;
		for (int k = 0; k <= VNUS; k++) begin
			wait_cnt[k] = -1;
		end
		rstn             = 1'b0;
		fsm_en_i         = 1'b1;
		termination_i    = 1'b0;
		vn_iter_update_i = '0;
		dn_iter_update_i = 1'b0;
		repeat (3) @(negedge read_clk);
		check_outputs("reset");
		rstn = 1'b1;

		while (layer_done < N_LAYERS) begin
			run_cycle("layers", 1'b1, 1'b0);
		end

		// restarts at random points of the schedule
		for (int e = 0; e < N_EVENTS; e++) begin
			gap = take_bits(4);
			repeat (gap) run_cycle("abort", 1'b1, 1'b0);
			layer_before = layer_cnt_o;
			if (take_bits(1) == 1) begin
				run_cycle("abort", 1'b1, 1'b1);
			end else begin
				drop = 1 + take_bits(2);
				repeat (drop) run_cycle("abort", 1'b0, 1'b0);
			end
			check_value("abort", "state_after_stop", 32'(vnu_state_pkg::INIT_LOAD), 32'(state_o));
			check_value("abort", "layer_kept", 32'(layer_before), 32'(layer_cnt_o));
		end
		repeat (40) run_cycle("abort", 1'b1, 1'b0);

		if (stall_cycles == 0) begin
			$display("no VNU_IB_RAM_PEND stall occurred, so the stall path was never exercised");
			err_cnt++;
		end
		if (hdd_cnt == 0) begin
			$display("hard_decision_done_o never pulsed during the run");
			err_cnt++;
		end
		$display("layers %0d, stall cycles %0d, errors %0d", layer_done, stall_cycles, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

// File: vnu_control_unit.sv
`timescale 1ns/100ps

// schedule controller top: fsm, strobe decode and ib-ram load trackers
module vnu_control_unit (
	input  logic                          read_clk,
	input  logic                          rstn,
	input  logic                          fsm_en_i,
	input  logic                          termination_i,
	input  vnu_timing_pkg::vnu_mask_t     vn_iter_update_i, // acks from vnu ib-ram writers
	input  logic                          dn_iter_update_i,
	output vnu_timing_pkg::vnu_mask_t     vnu_wr_o,
	output logic                          dnu_wr_o,
	output logic                          vnu_update_pend_o,
	output vnu_timing_pkg::vnu_mask_t     vnu_rd_o,
	output logic                          dnu_rd_o,
	output logic                          v2c_src_o,
	output logic                          v2c_bs_en_o,
	output logic                          v2c_pa_en_o,
	output logic                          v2c_mem_we_o,
	output logic                          hard_decision_done_o,
	output vnu_state_pkg::sched_state_t   state_o,
	output vnu_timing_pkg::layer_onehot_t layer_cnt_o,
	output logic                          last_layer_o,
	output logic                          layer_finish_o
);

	vnu_timing_pkg::stage_t    stage;
	vnu_timing_pkg::vnu_mask_t vnu_pending;
	vnu_timing_pkg::vnu_mask_t vnu_pipe_start;
	logic                      dnu_pipe_start;
	logic                      init_pulse;

	decode_sched_fsm u_decode_sched_fsm (
		.read_clk          (read_clk),
		.rstn              (rstn),
		.fsm_en_i          (fsm_en_i),
		.termination_i     (termination_i),
		.vnu_pending_i     (vnu_pending),
		.state_o           (state_o),
		.stage_o           (stage),
		.layer_cnt_o       (layer_cnt_o),
		.last_layer_o      (last_layer_o),
		.layer_finish_o    (layer_finish_o),
		.init_pulse_o      (init_pulse),
		.vnu_update_pend_o (vnu_update_pend_o)
	);

	pipe_strobe_gen u_pipe_strobe_gen (
		.read_clk             (read_clk),
		.rstn                 (rstn),
		.state_i              (state_o),
		.stage_i              (stage),
		.last_layer_i         (last_layer_o),
		.vnu_rd_o             (vnu_rd_o),
		.dnu_rd_o             (dnu_rd_o),
		.v2c_src_o            (v2c_src_o),
		.v2c_bs_en_o          (v2c_bs_en_o),
		.v2c_pa_en_o          (v2c_pa_en_o),
		.v2c_mem_we_o         (v2c_mem_we_o),
		.vnu_pipe_start_o     (vnu_pipe_start),
		.dnu_pipe_start_o     (dnu_pipe_start),
		.hard_decision_done_o (hard_decision_done_o)
	);

	////////////////////////////////////////
	// ib-ram load trackers
	////////////////////////////////////////
	for (genvar i = 0; i < vnu_timing_pkg::VNU_FUNC_NUM; i++) begin : g_vnu_load
		ib_ram_load_tracker u_vnu_tracker (
			.read_clk      (read_clk),
			.rstn          (rstn),
			.start_i       (vnu_pipe_start[i] | init_pulse), // init or pipe load
			.iter_update_i (vn_iter_update_i[i]),
			.wr_o          (vnu_wr_o[i]),
			.pending_o     (vnu_pending[i]) // stalls the fsm
		);
	end

	// dnu load is reported only, the schedule never waits on it
	ib_ram_load_tracker u_dnu_tracker (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.start_i       (dnu_pipe_start | init_pulse),
		.iter_update_i (dn_iter_update_i),
		.wr_o          (dnu_wr_o),
		.pending_o     ()
	);

endmodule

// File: vnu_state_pkg.sv
// states of the per-layer decoding schedule
package vnu_state_pkg;

	typedef enum logic [3:0] {
		INIT_LOAD       = 4'd0, // start of frame, ib-ram init loads
		CH_FETCH        = 4'd1, // channel message fetch
		MEM_FETCH       = 4'd2, // c2v memory read
		VNU_IB_RAM_PEND = 4'd3, // stall until vnu ib-rams are written
		VNU_PIPE        = 4'd4, // vnu pipeline running
		VNU_OUT         = 4'd5, // last vnu level
		BS_WB           = 4'd6, // barrel shift of v2c messages
		PAGE_ALIGN      = 4'd7,
		MEM_WB          = 4'd8, // v2c write back
		IDLE            = 4'd9  // gap before next layer
	} sched_state_t;

endpackage

// File: vnu_timing_pkg.sv
// pipeline depths and widths of the layered schedule
package vnu_timing_pkg;

	////////////////////////////////////////
	// schedule constants
	////////////////////////////////////////
	localparam int VNU_FUNC_NUM      = 2; // vnu decomposition functions, one ib-ram each
	localparam int LAYER_NUM         = 3; // layers per decoding iteration
	localparam int MEM_RD_LEVEL      = 2; // memory fetch takes two cycles
	localparam int VNU_FUNC_CYCLE    = 3; // read window of one 2-lut function
	localparam int VNU_PIPE_LEVEL    = 6; // last level is shared with the output stage
	localparam int PERMUTATION_LEVEL = 2; // barrel shifter latency
	localparam int IDLE_GAP          = 4; // idle cycles closing a layer
	localparam int STAGE_W           = 3; // wide enough for the longest timed state

	////////////////////////////////////////
	// vector types
	////////////////////////////////////////
	// one bit per vnu function
	typedef logic [VNU_FUNC_NUM-1:0] vnu_mask_t;

	// one-hot layer pointer, bit 0 is the first layer
	typedef logic [LAYER_NUM-1:0] layer_onehot_t;

	// cycle index inside the current state
	typedef logic [STAGE_W-1:0] stage_t;

endpackage
